// File: source/icache_pkg.sv
package icache_pkg;

  // address and bus data width
  localparam int XLEN = 32;
  // instruction width
  localparam int ILEN = 32;

  // cache geometry, as log2 of words per line and of line count
  localparam int WORD_BITS = 3;
  localparam int LINE_BITS = 3;

  // data RAM index is the line number followed by the word offset
  localparam int RAM_ADDR_BITS = LINE_BITS + WORD_BITS;

  // fully associative, so the tag is every address bit above the word offset
  localparam int TAG_BITS = XLEN - 2 - WORD_BITS;

  localparam int LINE_COUNT = 2 ** LINE_BITS;
  localparam int LINE_WORDS = 2 ** WORD_BITS;

  // refill sequencing in the controller
  // ARB waits for the bus grant, READ runs the word beats,
  // COMMIT validates the new tag, ABORT closes out a bus error
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    ARB    = 3'd1,
    READ   = 3'd2,
    COMMIT = 3'd3,
    ABORT  = 3'd4
  } refill_state_e;

endpackage

// File: source/icache_refill_if.sv
`timescale 1ns/1ps

interface icache_refill_if;

  // victim line and word index of the current beat
  logic [icache_pkg::LINE_BITS-1:0] line;
  logic [icache_pkg::WORD_BITS-1:0] word;

  // RAM write port of the refill
  logic                             wr;
  logic [icache_pkg::XLEN-1:0]      wdata;

  // tag of the missing address, latched by the controller
  logic [icache_pkg::TAG_BITS-1:0]  tag;

  // sequencing pulses
  logic                             start;
  logic                             done;
  logic                             abort;
  logic                             commit;

  modport ctrl (output start, output commit, output tag, input done, input abort);

  modport bus (
    input  start, input line, input tag,
    output word, output wr, output wdata, output done, output abort
  );

  modport tags (input commit, input tag, output line);

  modport ram (input line, input word, input wr, input wdata);

endinterface

// File: source/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store (
  input  logic                             clk_i,
  input  logic                             reset_i,

  // tag field of the fetch address
  input  logic [icache_pkg::TAG_BITS-1:0]  lookup_tag_i,
  output logic                             hit_o,
  output logic [icache_pkg::LINE_BITS-1:0] hit_line_o,

  icache_refill_if.tags                    refill
);

  logic [icache_pkg::LINE_COUNT-1:0] valid_q;
  logic [icache_pkg::TAG_BITS-1:0]   tag_q [icache_pkg::LINE_COUNT];

  // round-robin pointer to the line the next refill replaces
  logic [icache_pkg::LINE_BITS-1:0]  victim_q;

  // per-line match vector
  logic [icache_pkg::LINE_COUNT-1:0] match;

  always_comb begin
    for (int i = 0; i < icache_pkg::LINE_COUNT; i++) begin
      match[i] = valid_q[i] && (tag_q[i] == lookup_tag_i);
    end
  end

  assign hit_o = |match;

  // a tag is only ever held by one valid line, so the encoder
  // never sees more than one bit set
  always_comb begin
    hit_line_o = '0;
    for (int i = 0; i < icache_pkg::LINE_COUNT; i++) begin
      if (match[i]) begin
        hit_line_o = i[icache_pkg::LINE_BITS-1:0];
      end
    end
  end

  // the victim stays put for the whole refill, so the data RAM
  // writes go to the same line that commit later validates
  assign refill.line = victim_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (refill.commit) begin
      valid_q[victim_q] <= 1'b1;
      victim_q          <= victim_q + 1'b1;
    end
  end

  // refill tag lands in the victim line on commit
  always_ff @(posedge clk_i) begin
    if (refill.commit) begin
      tag_q[victim_q] <= refill.tag;
    end
  end

endmodule

// File: source/icache_data_ram.sv
`timescale 1ns/1ps

module icache_data_ram (
  input  logic                             clk_i,

  // read port addressed by the hit line and the word offset
  input  logic                             rd_en_i,
  input  logic [icache_pkg::LINE_BITS-1:0] rd_line_i,
  input  logic [icache_pkg::WORD_BITS-1:0] rd_word_i,
  output logic [icache_pkg::ILEN-1:0]      data_o,

  icache_refill_if.ram                     refill
);

  // every line of the cache, word by word
  logic [icache_pkg::ILEN-1:0]          mem [icache_pkg::LINE_COUNT * icache_pkg::LINE_WORDS];
  logic [icache_pkg::RAM_ADDR_BITS-1:0] rd_addr;
  logic [icache_pkg::RAM_ADDR_BITS-1:0] wr_addr;

  assign rd_addr = {rd_line_i, rd_word_i};
  assign wr_addr = {refill.line, refill.word};

  // write port takes one word per acknowledged beat
  always_ff @(posedge clk_i) begin
    if (refill.wr) begin
      mem[wr_addr] <= refill.wdata;
    end
  end

  // output register only loads on a hit, so the last
  // instruction stays visible while a refill runs
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      data_o <= mem[rd_addr];
    end
  end

endmodule

// File: source/icache_refill_ctrl.sv
`timescale 1ns/1ps

module icache_refill_ctrl (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // core side
  input  logic                         advance_i,
  input  logic [icache_pkg::XLEN-1:0]  addr_i,
  output logic                         busy_o,
  output logic                         misaligned_o,
  output logic                         fetch_err_o,

  // lookup result from the tag store
  input  logic                         hit_i,

  // bus arbiter
  output logic                         ctrl_req_o,
  input  logic                         ctrl_grant_i,

  // loads the data RAM output register
  output logic                         ram_rd_o,

  icache_refill_if.ctrl                refill
);

  icache_pkg::refill_state_e          state_q;
  logic [icache_pkg::TAG_BITS-1:0]    tag_q;

  logic lookup;
  logic misaligned;
  logic miss;

  // an advance only counts while no refill is pending
  assign lookup     = advance_i & ~busy_o;
  assign misaligned = |addr_i[1:0];
  assign miss       = lookup & ~misaligned & ~hit_i;
  assign ram_rd_o   = lookup & ~misaligned & hit_i;

  // start fires on the grant edge, the bus master loads its address there
  assign refill.start  = (state_q == icache_pkg::ARB) & ctrl_grant_i;
  assign refill.commit = (state_q == icache_pkg::COMMIT);
  assign refill.tag    = tag_q;

  // word offset is not kept, a refill always runs from word zero
  always_ff @(posedge clk_i) begin
    if (miss) begin
      tag_q <= addr_i[icache_pkg::XLEN-1:icache_pkg::XLEN-icache_pkg::TAG_BITS];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= icache_pkg::IDLE;
      busy_o       <= 1'b0;
      ctrl_req_o   <= 1'b0;
      misaligned_o <= 1'b0;
      fetch_err_o  <= 1'b0;
    end else begin
      // status pulses last a single cycle
      misaligned_o <= lookup & misaligned;
      fetch_err_o  <= 1'b0;

      case (state_q)
        // busy is already low in ABORT, so it accepts lookups like IDLE
        icache_pkg::IDLE,
        icache_pkg::ABORT: begin
          state_q <= icache_pkg::IDLE;
          if (miss) begin
            busy_o     <= 1'b1;
            ctrl_req_o <= 1'b1;
            state_q    <= icache_pkg::ARB;
          end
        end

        icache_pkg::ARB: begin
          if (ctrl_grant_i) begin
            state_q <= icache_pkg::READ;
          end
        end

        icache_pkg::READ: begin
          if (refill.abort) begin
            busy_o      <= 1'b0;
            ctrl_req_o  <= 1'b0;
            fetch_err_o <= 1'b1;
            state_q     <= icache_pkg::ABORT;
          end else if (refill.done) begin
            state_q <= icache_pkg::COMMIT;
          end
        end

        // tag store takes the commit on this edge, so the line hits
        // as soon as busy is seen low
        icache_pkg::COMMIT: begin
          busy_o     <= 1'b0;
          ctrl_req_o <= 1'b0;
          state_q    <= icache_pkg::IDLE;
        end

        default: begin
          state_q <= icache_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/icache_bus_master.sv
`timescale 1ns/1ps

module icache_bus_master (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // Wishbone classic master
  input  logic [icache_pkg::XLEN-1:0]  master_dat_i,
  input  logic                         ack_i,
  input  logic                         err_i,
  output logic [icache_pkg::XLEN-3:0]  adr_o,
  output logic                         stb_o,
  output logic                         cyc_o,
  output logic [3:0]                   sel_o,

  icache_refill_if.bus                 refill
);

  logic [icache_pkg::XLEN-3:0]      adr_q;
  logic [icache_pkg::WORD_BITS-1:0] word_q;
  logic                             stb_q;
  logic                             done_q;
  logic                             abort_q;
  logic                             beat;

  // err takes priority if a slave raises both
  assign beat = stb_q & ack_i & ~err_i;

  // whole-word fetches only
  assign sel_o = 4'b1111;
  assign stb_o = stb_q;
  assign cyc_o = stb_q;
  assign adr_o = adr_q;

  assign refill.word  = word_q;
  assign refill.wr    = beat;
  assign refill.wdata = master_dat_i;
  assign refill.done  = done_q;
  assign refill.abort = abort_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stb_q   <= 1'b0;
      done_q  <= 1'b0;
      abort_q <= 1'b0;
    end else begin
      done_q  <= 1'b0;
      abort_q <= 1'b0;
      if (refill.start) begin
        stb_q <= 1'b1;
      end else if (stb_q && err_i) begin
        stb_q   <= 1'b0;
        abort_q <= 1'b1;
      end else if (beat && (&word_q)) begin
        // last word of the line
        stb_q  <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // line base is the tag with a zero word offset
  always_ff @(posedge clk_i) begin
    if (refill.start) begin
      adr_q  <= {refill.tag, {icache_pkg::WORD_BITS{1'b0}}};
      word_q <= '0;
    end else if (beat) begin
      adr_q  <= adr_q + 1'b1;
      word_q <= word_q + 1'b1;
    end
  end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // core fetch port
  input  logic                         advance_i,
  input  logic [icache_pkg::XLEN-1:0]  addr_i,
  output logic                         busy_o,
  output logic [icache_pkg::ILEN-1:0]  instruction_o,
  output logic                         misaligned_o,
  output logic                         fetch_err_o,

  // bus arbiter
  output logic                         ctrl_req_o,
  input  logic                         ctrl_grant_i,

  // Wishbone classic master
  input  logic [icache_pkg::XLEN-1:0]  master_dat_i,
  input  logic                         ack_i,
  input  logic                         err_i,
  output logic [icache_pkg::XLEN-1:2]  adr_o,
  output logic                         cyc_o,
  output logic                         stb_o,
  output logic [3:0]                   sel_o
);

  icache_refill_if refill_if ();

  logic                             hit;
  logic [icache_pkg::LINE_BITS-1:0] hit_line;
  logic                             ram_rd;
  logic [icache_pkg::TAG_BITS-1:0]  lookup_tag;
  logic [icache_pkg::WORD_BITS-1:0] word_offset;

  // fetch address split into tag and word offset, byte bits are ignored
  assign lookup_tag  = addr_i[icache_pkg::XLEN-1:icache_pkg::XLEN-icache_pkg::TAG_BITS];
  assign word_offset = addr_i[icache_pkg::WORD_BITS+1:2];

  icache_refill_ctrl icache_refill_ctrl_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .advance_i    (advance_i),
    .addr_i       (addr_i),
    .busy_o       (busy_o),
    .misaligned_o (misaligned_o),
    .fetch_err_o  (fetch_err_o),
    .hit_i        (hit),
    .ctrl_req_o   (ctrl_req_o),
    .ctrl_grant_i (ctrl_grant_i),
    .ram_rd_o     (ram_rd),
    .refill       (refill_if.ctrl)
  );

  icache_tag_store icache_tag_store_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_tag_i (lookup_tag),
    .hit_o        (hit),
    .hit_line_o   (hit_line),
    .refill       (refill_if.tags)
  );

  icache_data_ram icache_data_ram_inst (
    .clk_i     (clk_i),
    .rd_en_i   (ram_rd),
    .rd_line_i (hit_line),
    .rd_word_i (word_offset),
    .data_o    (instruction_o),
    .refill    (refill_if.ram)
  );

  icache_bus_master icache_bus_master_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .master_dat_i (master_dat_i),
    .ack_i        (ack_i),
    .err_i        (err_i),
    .adr_o        (adr_o),
    .stb_o        (stb_o),
    .cyc_o        (cyc_o),
    .sel_o        (sel_o),
    .refill       (refill_if.bus)
  );

endmodule

// File: verif/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model (
  input  logic        clk_i,
  input  logic        reset_i,

  // arbiter side
  input  logic        ctrl_req_i,
  output logic        ctrl_grant_o,

  // Wishbone classic slave
  input  logic [29:0] adr_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        err_o
);

  integer seed;
  integer ack_wait;
  integer grant_wait;

  // word contents, a mix of every address bit
  function automatic logic [31:0] word_data(input logic [29:0] word_addr);
    logic [31:0] a;
    a = {2'b00, word_addr};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  // byte addresses 0x8000 to 0x80ff answer with err
  function automatic logic in_error_region(input logic [29:0] word_addr);
    return word_addr[29:6] == 24'h000080;
  endfunction

  initial begin
    seed         = 60;
    ack_wait     = -1;
    grant_wait   = -1;
    ctrl_grant_o = 1'b0;
    dat_o        = '0;
    ack_o        = 1'b0;
    err_o        = 1'b0;
  end

  // one response per beat after 0 to 3 wait cycles
  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      ack_wait = -1;
    end else if (ack_o || err_o) begin
      // single-cycle response, the master moves on at this edge
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (ack_wait < 0) begin
        ack_wait = $unsigned($random(seed)) % 4;
      end
      if (ack_wait == 0) begin
        ack_wait = -1;
        if (in_error_region(adr_i)) begin
          err_o <= 1'b1;
        end else begin
          ack_o <= 1'b1;
          dat_o <= word_data(adr_i);
        end
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  // grant after 0 to 4 cycles, held until the request drops
  always @(posedge clk_i) begin
    if (reset_i || !ctrl_req_i) begin
      ctrl_grant_o <= 1'b0;
      grant_wait   = -1;
    end else if (!ctrl_grant_o) begin
      if (grant_wait < 0) begin
        grant_wait = $unsigned($random(seed)) % 5;
      end
      if (grant_wait == 0) begin
        ctrl_grant_o <= 1'b1;
      end else begin
        grant_wait = grant_wait - 1;
      end
    end
  end

endmodule

// File: verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  localparam int RESET_CYCLES     = 8;
  localparam int NUM_FETCHES      = 300;
  localparam int DIRECTED_FETCHES = 11;
  // 8 beats of up to 4 waits plus the ack cycle, grant delay, controller overhead
  localparam int FETCH_CYCLES     = 8 * (4 + 2) + (4 + 2) + 8;
  localparam int WATCHDOG_CYCLES  =
    2 * (NUM_FETCHES + DIRECTED_FETCHES) * FETCH_CYCLES + RESET_CYCLES + 50;

  logic        clk_i;
  logic        reset_i;
  logic        advance_i;
  logic [31:0] addr_i;
  logic        busy_o;
  logic [31:0] instruction_o;
  logic        misaligned_o;
  logic        fetch_err_o;
  logic        ctrl_req_o;
  logic        ctrl_grant_i;
  logic [31:0] master_dat_i;
  logic        ack_i;
  logic        err_i;
  logic [29:0] adr_o;
  logic        cyc_o;
  logic        stb_o;
  logic [3:0]  sel_o;

  integer      seed;

  // reference cache, tag is the byte address above the line offset
  logic [26:0] model_tag [8];
  logic [7:0]  model_valid;
  logic [2:0]  model_victim;

  // bus beat tracking
  logic        refill_active;
  logic [29:0] refill_base;
  integer      beat_count;

  logic        instr_known;
  logic [31:0] last_instr;

  icache_top icache_top_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .advance_i     (advance_i),
    .addr_i        (addr_i),
    .busy_o        (busy_o),
    .instruction_o (instruction_o),
    .misaligned_o  (misaligned_o),
    .fetch_err_o   (fetch_err_o),
    .ctrl_req_o    (ctrl_req_o),
    .ctrl_grant_i  (ctrl_grant_i),
    .master_dat_i  (master_dat_i),
    .ack_i         (ack_i),
    .err_i         (err_i),
    .adr_o         (adr_o),
    .cyc_o         (cyc_o),
    .stb_o         (stb_o),
    .sel_o         (sel_o)
  );

  icache_mem_model icache_mem_model_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ctrl_req_i   (ctrl_req_o),
    .ctrl_grant_o (ctrl_grant_i),
    .adr_i        (adr_o),
    .cyc_i        (cyc_o),
    .stb_i        (stb_o),
    .dat_o        (master_dat_i),
    .ack_o        (ack_i),
    .err_o        (err_i)
  );

  always #2 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected 0x%h, got 0x%h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // memory contents as the slave serves them
  function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
    logic [31:0] a;
    a = {2'b00, byte_addr[31:2]};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic is_error_addr(input logic [31:0] byte_addr);
    return byte_addr[31:8] == 24'h000080;
  endfunction

  function automatic logic model_hit(input logic [31:0] byte_addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (model_valid[i] && model_tag[i] == byte_addr[31:5]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // one advance, then the expected response for hit, miss or misaligned
  task automatic fetch_once(input logic [31:0] addr, output logic missed);
    logic predict_hit;
    logic predict_err;
    predict_hit = model_hit(addr);
    predict_err = is_error_addr(addr);
    missed      = 1'b0;
    @(posedge clk_i);
    advance_i <= 1'b1;
    addr_i    <= addr;
    @(posedge clk_i);
    advance_i <= 1'b0;
    @(negedge clk_i);
    if (addr[1:0] != 2'b00) begin
      check_value("misaligned_o", misaligned_o, 1'b1);
      check_value("busy_o", busy_o, 1'b0);
      if (instr_known) begin
        check_value("instruction_o", instruction_o, last_instr);
      end
      @(negedge clk_i);
      check_value("misaligned_o", misaligned_o, 1'b0);
    end else if (predict_hit) begin
      check_value("busy_o", busy_o, 1'b0);
      check_value("misaligned_o", misaligned_o, 1'b0);
      check_value("instruction_o", instruction_o, expected_word(addr));
      instr_known = 1'b1;
      last_instr  = expected_word(addr);
    end else begin
      missed = 1'b1;
      check_value("busy_o", busy_o, 1'b1);
      check_value("ctrl_req_o", ctrl_req_o, 1'b1);
      check_value("misaligned_o", misaligned_o, 1'b0);
      refill_base   = {addr[31:5], 3'b000};
      beat_count    = 0;
      refill_active = 1'b1;
      while (busy_o) begin
        @(negedge clk_i);
      end
      refill_active = 1'b0;
      check_value("fetch_err_o", fetch_err_o, predict_err);
      check_value("ctrl_req_o", ctrl_req_o, 1'b0);
      // an aborted line stays invalid and the victim pointer holds
      if (!predict_err) begin
        check_value("beat_count", beat_count, 32'd8);
        model_tag[model_victim]   = addr[31:5];
        model_valid[model_victim] = 1'b1;
        model_victim              = model_victim + 1'b1;
      end
      @(negedge clk_i);
      check_value("fetch_err_o", fetch_err_o, 1'b0);
    end
  endtask

  // the core presents a missed address again once busy drops
  task automatic fetch_and_retry(input logic [31:0] addr);
    logic missed;
    fetch_once(addr, missed);
    if (missed) begin
      fetch_once(addr, missed);
    end
  endtask

  // Wishbone beat monitor
  always @(negedge clk_i) begin
    if (!reset_i) begin
      check_value("cyc_o", cyc_o, stb_o);
      check_value("sel_o", sel_o, 4'hf);
      if (!refill_active) begin
        check_value("stb_o", stb_o, 1'b0);
      end
      if (stb_o && ack_i) begin
        check_value("adr_o", adr_o, refill_base + beat_count);
        beat_count = beat_count + 1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: fetch sequence still running after %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    advance_i     = 1'b0;
    addr_i        = '0;
    seed          = 60;
    model_valid   = '0;
    model_victim  = '0;
    refill_active = 1'b0;
    refill_base   = '0;
    beat_count    = 0;
    instr_known   = 1'b0;
    last_instr    = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    check_value("ctrl_req_o", ctrl_req_o, 1'b0);
    check_value("stb_o", stb_o, 1'b0);
    check_value("cyc_o", cyc_o, 1'b0);
    check_value("misaligned_o", misaligned_o, 1'b0);
    check_value("fetch_err_o", fetch_err_o, 1'b0);

    // nine distinct lines wrap the victim pointer, evicting the first
    for (int i = 0; i < 9; i++) begin
      fetch_and_retry(32'h1000 + i * 32 + 4);
    end
    fetch_and_retry(32'h1000 + 32 + 8);
    fetch_and_retry(32'h1000 + 8);

    // random mix over 16 lines, the error region and misaligned addresses
    for (int n = 0; n < NUM_FETCHES; n++) begin
      rnd = $random(seed);
      if (rnd[3:0] == 4'd0) begin
        addr = 32'h8000 + {rnd[6:4], 5'b00000} + {rnd[10:8], 2'b00};
      end else begin
        addr = 32'h1000 + {rnd[7:4], 5'b00000} + {rnd[10:8], 2'b00};
        if (rnd[3:0] == 4'd1) begin
          addr[1:0] = (rnd[12:11] == 2'b00) ? 2'b01 : rnd[12:11];
        end
      end
      fetch_and_retry(addr);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: src.f
source/icache_pkg.sv
source/icache_refill_if.sv
source/icache_tag_store.sv
source/icache_data_ram.sv
source/icache_refill_ctrl.sv
source/icache_bus_master.sv
source/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv
